//--- verilog/hd_consts.svh
`ifndef HD_CONSTS_SVH
`define HD_CONSTS_SVH

// Link payload widths
`define HD_ADDR_W      32
`define HD_DATA_W      64
`define HD_CPU_ID_W    4
// Memory side carries one extra id bit
`define HD_MEM_ID_W    5

// Configuration port
`define HD_CFG_ADDR_W  4
`define HD_CFG_DATA_W  32

// Counter bank
`define HD_NUM_CNT     4
`define HD_OUTST_W     8

// Event codes within one link
`define HD_EV_RD       0
`define HD_EV_WR       1
`define HD_EV_RSP      2
`define HD_EV_BUSY     3

// Register groups, word addresses
`define HD_REG_CNT     0
`define HD_REG_SEL     4
`define HD_REG_THR     8
`define HD_REG_IRQ     12

`endif

//--- verilog/hd_pkg.sv
`include "hd_consts.svh"

package hd_pkg;

  // Request on the CPU side link
  typedef struct packed {
    logic [`HD_CPU_ID_W-1:0] id;
    logic [`HD_ADDR_W-1:0]   addr;
    logic                    write_en;
    logic [`HD_DATA_W-1:0]   wdata;
  } cpu_req_t;

  // Request on the memory side link, wider id
  typedef struct packed {
    logic [`HD_MEM_ID_W-1:0] id;
    logic [`HD_ADDR_W-1:0]   addr;
    logic                    write_en;
    logic [`HD_DATA_W-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic [`HD_DATA_W-1:0] data;
    logic [1:0]            status;
  } link_rsp_t;

  // Per link event strobes
  typedef struct packed {
    logic rd;
    logic wr;
    logic rsp;
    logic busy;
  } link_events_t;

  typedef struct packed {
    logic                      write_en;
    logic [`HD_CFG_ADDR_W-1:0] addr;
    logic [`HD_CFG_DATA_W-1:0] wdata;
  } cfg_req_t;

  // Counter source select, link 0 is CPU and 1 is memory
  typedef struct packed {
    logic       en;
    logic       link;
    logic [1:0] ev;
  } cnt_sel_t;

endpackage

//--- verilog/bus_event_probe.sv
`timescale 1ns/10ps
`include "hd_consts.svh"

module bus_event_probe
  import hd_pkg::*;
#(
  parameter type req_t = cpu_req_t
) (
  input  logic         clk_i,
  input  logic         reset_i,
  input  req_t         req_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  output req_t         req_o,
  output logic         req_valid_o,
  input  logic         req_ready_i,
  input  link_rsp_t    rsp_i,
  input  logic         rsp_valid_i,
  output logic         rsp_ready_o,
  output link_rsp_t    rsp_o,
  output logic         rsp_valid_o,
  input  logic         rsp_ready_i,
  output link_events_t events_o
);

  logic                   req_fire;
  logic                   rsp_fire;
  logic [`HD_OUTST_W-1:0] outst_q;
  link_events_t           events_q;

  // Streams go straight through, no added latency
  assign req_o       = req_i;
  assign req_valid_o = req_valid_i;
  assign req_ready_o = req_ready_i;
  assign rsp_o       = rsp_i;
  assign rsp_valid_o = rsp_valid_i;
  assign rsp_ready_o = rsp_ready_i;

  assign req_fire = req_valid_i & req_ready_i;
  assign rsp_fire = rsp_valid_i & rsp_ready_i;

  // Outstanding requests, saturating at both ends
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outst_q <= '0;
    end else if (req_fire && !rsp_fire) begin
      if (outst_q != '1) begin
        outst_q <= outst_q + 1'b1;
      end
    end else if (rsp_fire && !req_fire) begin
      if (outst_q != '0) begin
        outst_q <= outst_q - 1'b1;
      end
    end
  end

  // Strobes lag the handshake by one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      events_q <= '0;
    end else begin
      events_q.rd   <= req_fire & ~req_i.write_en;
      events_q.wr   <= req_fire & req_i.write_en;
      events_q.rsp  <= rsp_fire;
      // Busy reflects the count before this edge
      events_q.busy <= (outst_q != '0);
    end
  end

  assign events_o = events_q;

endmodule

//--- verilog/pmu_counters.sv
`timescale 1ns/10ps
`include "hd_consts.svh"

module pmu_counters
  import hd_pkg::*;
(
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  link_events_t                                 cpu_events_i,
  input  link_events_t                                 mem_events_i,
  input  cnt_sel_t [`HD_NUM_CNT-1:0]                   sel_i,
  input  logic     [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] thr_i,
  input  logic     [`HD_NUM_CNT-1:0]                   cnt_load_i,
  input  logic     [`HD_CFG_DATA_W-1:0]                load_data_i,
  input  logic     [`HD_NUM_CNT-1:0]                   irq_clr_i,
  output logic     [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] cnt_o,
  output logic     [`HD_NUM_CNT-1:0]                   irq_o
);

  logic [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] cnt_q;
  logic [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] cnt_d;
  logic [`HD_NUM_CNT-1:0]                     hit;
  logic [`HD_NUM_CNT-1:0]                     upd;
  logic [`HD_NUM_CNT-1:0]                     thr_match;
  logic [`HD_NUM_CNT-1:0]                     irq_q;

  // Event code to strobe of one link
  function automatic logic pick_event(link_events_t ev, logic [1:0] code);
    logic strobe;
    case (code)
      `HD_EV_RD:   strobe = ev.rd;
      `HD_EV_WR:   strobe = ev.wr;
      `HD_EV_RSP:  strobe = ev.rsp;
      `HD_EV_BUSY: strobe = ev.busy;
      default:     strobe = 1'b0;
    endcase
    return strobe;
  endfunction

  always_comb begin
    for (int i = 0; i < `HD_NUM_CNT; i++) begin
      hit[i] = sel_i[i].en &
               pick_event(sel_i[i].link ? mem_events_i : cpu_events_i, sel_i[i].ev);
      upd[i] = cnt_load_i[i] | hit[i];
      // A load wins over a same-cycle increment
      cnt_d[i] = cnt_load_i[i] ? load_data_i : cnt_q[i] + 1'b1;
      // Zero threshold means no interrupt
      thr_match[i] = upd[i] && (thr_i[i] != '0) && (cnt_d[i] == thr_i[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
      irq_q <= '0;
    end else begin
      for (int i = 0; i < `HD_NUM_CNT; i++) begin
        if (upd[i]) begin
          cnt_q[i] <= cnt_d[i];
        end
        // Sticky until cleared, a new match beats the clear
        if (thr_match[i]) begin
          irq_q[i] <= 1'b1;
        end else if (irq_clr_i[i]) begin
          irq_q[i] <= 1'b0;
        end
      end
    end
  end

  assign cnt_o = cnt_q;
  assign irq_o = irq_q;

endmodule

//--- verilog/pmu_cfg_regs.sv
`timescale 1ns/10ps
`include "hd_consts.svh"

module pmu_cfg_regs
  import hd_pkg::*;
(
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  cfg_req_t                                       cfg_req_i,
  input  logic                                           cfg_req_valid_i,
  output logic                                           cfg_req_ready_o,
  output logic     [`HD_CFG_DATA_W-1:0]                  cfg_rsp_data_o,
  output logic                                           cfg_rsp_valid_o,
  input  logic                                           cfg_rsp_ready_i,
  output cnt_sel_t [`HD_NUM_CNT-1:0]                     sel_o,
  output logic     [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] thr_o,
  output logic     [`HD_NUM_CNT-1:0]                     cnt_load_o,
  output logic     [`HD_CFG_DATA_W-1:0]                  load_data_o,
  output logic     [`HD_NUM_CNT-1:0]                     irq_clr_o,
  input  logic     [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] cnt_i,
  input  logic     [`HD_NUM_CNT-1:0]                     irq_i
);

  localparam int idx_w = $clog2(`HD_NUM_CNT);

  logic                                       accept;
  logic                                       wr_acc;
  logic [idx_w-1:0]                           idx;
  logic [`HD_CFG_ADDR_W-1:0]                  grp_base;
  logic [`HD_CFG_DATA_W-1:0]                  rd_data;
  cnt_sel_t [`HD_NUM_CNT-1:0]                 sel_q;
  logic [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] thr_q;
  logic                                       rsp_valid_q;
  logic [`HD_CFG_DATA_W-1:0]                  rsp_data_q;

  // One request in flight at a time
  assign cfg_req_ready_o = ~rsp_valid_q;
  assign accept = cfg_req_valid_i & cfg_req_ready_o;
  assign wr_acc = accept & cfg_req_i.write_en;

  // Upper address bits pick the group, low bits the counter
  assign idx      = cfg_req_i.addr[idx_w-1:0];
  assign grp_base = {cfg_req_i.addr[`HD_CFG_ADDR_W-1:idx_w], idx_w'(0)};

  always_comb begin
    rd_data = '0;
    case (grp_base)
      `HD_REG_CNT: rd_data = cnt_i[idx];
      `HD_REG_SEL: rd_data = `HD_CFG_DATA_W'(sel_q[idx]);
      `HD_REG_THR: rd_data = thr_q[idx];
      `HD_REG_IRQ: begin
        // Status lives only in the first word of the group
        if (idx == '0) begin
          rd_data = `HD_CFG_DATA_W'(irq_i);
        end
      end
      default: rd_data = '0;
    endcase
  end

  // Load and clear strobes, valid in the accepting cycle only
  always_comb begin
    cnt_load_o = '0;
    irq_clr_o  = '0;
    if (wr_acc && grp_base == `HD_REG_CNT) begin
      cnt_load_o[idx] = 1'b1;
    end
    if (wr_acc && grp_base == `HD_REG_IRQ && idx == '0) begin
      irq_clr_o = cfg_req_i.wdata[`HD_NUM_CNT-1:0];
    end
  end

  assign load_data_o = cfg_req_i.wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q       <= '0;
      thr_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (wr_acc && grp_base == `HD_REG_SEL) begin
        sel_q[idx] <= cnt_sel_t'(cfg_req_i.wdata[$bits(cnt_sel_t)-1:0]);
      end
      if (wr_acc && grp_base == `HD_REG_THR) begin
        thr_q[idx] <= cfg_req_i.wdata;
      end
      if (accept) begin
        rsp_valid_q <= 1'b1;
      end else if (cfg_rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_data_q <= cfg_req_i.write_en ? '0 : rd_data;
    end
  end

  assign cfg_rsp_valid_o = rsp_valid_q;
  assign cfg_rsp_data_o  = rsp_data_q;
  assign sel_o           = sel_q;
  assign thr_o           = thr_q;

endmodule

//--- verilog/host_pmu_top.sv
`timescale 1ns/10ps
`include "hd_consts.svh"

module host_pmu_top
  import hd_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  // CPU side link
  input  cpu_req_t                  cpu_req_i,
  input  logic                      cpu_req_valid_i,
  output logic                      cpu_req_ready_o,
  output cpu_req_t                  cpu_req_o,
  output logic                      cpu_req_valid_o,
  input  logic                      cpu_req_ready_i,
  input  link_rsp_t                 cpu_rsp_i,
  input  logic                      cpu_rsp_valid_i,
  output logic                      cpu_rsp_ready_o,
  output link_rsp_t                 cpu_rsp_o,
  output logic                      cpu_rsp_valid_o,
  input  logic                      cpu_rsp_ready_i,
  // Memory side link
  input  mem_req_t                  mem_req_i,
  input  logic                      mem_req_valid_i,
  output logic                      mem_req_ready_o,
  output mem_req_t                  mem_req_o,
  output logic                      mem_req_valid_o,
  input  logic                      mem_req_ready_i,
  input  link_rsp_t                 mem_rsp_i,
  input  logic                      mem_rsp_valid_i,
  output logic                      mem_rsp_ready_o,
  output link_rsp_t                 mem_rsp_o,
  output logic                      mem_rsp_valid_o,
  input  logic                      mem_rsp_ready_i,
  // Configuration port
  input  cfg_req_t                  cfg_req_i,
  input  logic                      cfg_req_valid_i,
  output logic                      cfg_req_ready_o,
  output logic [`HD_CFG_DATA_W-1:0] cfg_rsp_data_o,
  output logic                      cfg_rsp_valid_o,
  input  logic                      cfg_rsp_ready_i,
  output logic [`HD_NUM_CNT-1:0]    irq_o
);

  link_events_t                               cpu_events;
  link_events_t                               mem_events;
  cnt_sel_t [`HD_NUM_CNT-1:0]                 sel;
  logic [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] thr;
  logic [`HD_NUM_CNT-1:0]                     cnt_load;
  logic [`HD_CFG_DATA_W-1:0]                  load_data;
  logic [`HD_NUM_CNT-1:0]                     irq_clr;
  logic [`HD_NUM_CNT-1:0][`HD_CFG_DATA_W-1:0] cnt;

  bus_event_probe #(
    .req_t       ( cpu_req_t       )
  ) u_cpu_probe (
    .clk_i       ( clk_i           ),
    .reset_i     ( reset_i         ),
    .req_i       ( cpu_req_i       ),
    .req_valid_i ( cpu_req_valid_i ),
    .req_ready_o ( cpu_req_ready_o ),
    .req_o       ( cpu_req_o       ),
    .req_valid_o ( cpu_req_valid_o ),
    .req_ready_i ( cpu_req_ready_i ),
    .rsp_i       ( cpu_rsp_i       ),
    .rsp_valid_i ( cpu_rsp_valid_i ),
    .rsp_ready_o ( cpu_rsp_ready_o ),
    .rsp_o       ( cpu_rsp_o       ),
    .rsp_valid_o ( cpu_rsp_valid_o ),
    .rsp_ready_i ( cpu_rsp_ready_i ),
    .events_o    ( cpu_events      )
  );

  bus_event_probe #(
    .req_t       ( mem_req_t       )
  ) u_mem_probe (
    .clk_i       ( clk_i           ),
    .reset_i     ( reset_i         ),
    .req_i       ( mem_req_i       ),
    .req_valid_i ( mem_req_valid_i ),
    .req_ready_o ( mem_req_ready_o ),
    .req_o       ( mem_req_o       ),
    .req_valid_o ( mem_req_valid_o ),
    .req_ready_i ( mem_req_ready_i ),
    .rsp_i       ( mem_rsp_i       ),
    .rsp_valid_i ( mem_rsp_valid_i ),
    .rsp_ready_o ( mem_rsp_ready_o ),
    .rsp_o       ( mem_rsp_o       ),
    .rsp_valid_o ( mem_rsp_valid_o ),
    .rsp_ready_i ( mem_rsp_ready_i ),
    .events_o    ( mem_events      )
  );

  pmu_counters u_counters (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .cpu_events_i ( cpu_events ),
    .mem_events_i ( mem_events ),
    .sel_i        ( sel        ),
    .thr_i        ( thr        ),
    .cnt_load_i   ( cnt_load   ),
    .load_data_i  ( load_data  ),
    .irq_clr_i    ( irq_clr    ),
    .cnt_o        ( cnt        ),
    .irq_o        ( irq_o      )
  );

  pmu_cfg_regs u_cfg (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_req_valid_i ( cfg_req_valid_i ),
    .cfg_req_ready_o ( cfg_req_ready_o ),
    .cfg_rsp_data_o  ( cfg_rsp_data_o  ),
    .cfg_rsp_valid_o ( cfg_rsp_valid_o ),
    .cfg_rsp_ready_i ( cfg_rsp_ready_i ),
    .sel_o           ( sel             ),
    .thr_o           ( thr             ),
    .cnt_load_o      ( cnt_load        ),
    .load_data_o     ( load_data       ),
    .irq_clr_o       ( irq_clr         ),
    .cnt_i           ( cnt             ),
    .irq_i           ( irq_o           )
  );

endmodule

//--- bench/host_pmu_asserts.sv
`timescale 1ns/10ps
`include "hd_consts.svh"

module host_pmu_asserts
  import hd_pkg::*;
(
  input logic         clk_i,
  input logic         reset_i,
  input cpu_req_t     cpu_req_o,
  input logic         cpu_req_valid_o,
  input logic         cpu_req_ready_i,
  input link_rsp_t    cpu_rsp_o,
  input logic         cpu_rsp_valid_o,
  input logic         cpu_rsp_ready_i,
  input mem_req_t     mem_req_o,
  input logic         mem_req_valid_o,
  input logic         mem_req_ready_i,
  input link_rsp_t    mem_rsp_o,
  input logic         mem_rsp_valid_o,
  input logic         mem_rsp_ready_i,
  input logic         cfg_req_valid_i,
  input logic         cfg_req_ready_o,
  input logic         cfg_rsp_valid_o,
  input link_events_t cpu_events_i,
  input link_events_t mem_events_i
);

  // Streams leaving the DUT hold valid and payload while stalled
  cpu_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    cpu_req_valid_o && !cpu_req_ready_i |=> cpu_req_valid_o && $stable(cpu_req_o))
    else $error("CPU request dropped or changed while stalled");
  cpu_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    cpu_rsp_valid_o && !cpu_rsp_ready_i |=> cpu_rsp_valid_o && $stable(cpu_rsp_o))
    else $error("CPU response dropped or changed while stalled");
  mem_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else $error("memory request dropped or changed while stalled");
  mem_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_rsp_valid_o && !mem_rsp_ready_i |=> mem_rsp_valid_o && $stable(mem_rsp_o))
    else $error("memory response dropped or changed while stalled");

  cfg_rsp_follows: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_req_valid_i && cfg_req_ready_o |=> cfg_rsp_valid_o)
    else $error("config response missing one cycle after accept");
  cfg_rsp_cause: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(cfg_rsp_valid_o) |-> $past(cfg_req_valid_i && cfg_req_ready_o))
    else $error("config response rose without an accepted request");

  events_in_reset: assert property (@(posedge clk_i)
    reset_i |=> cpu_events_i == '0 && mem_events_i == '0)
    else $error("event strobe high during reset");

endmodule

bind host_pmu_top host_pmu_asserts u_asserts (
  .clk_i           ( clk_i           ),
  .reset_i         ( reset_i         ),
  .cpu_req_o       ( cpu_req_o       ),
  .cpu_req_valid_o ( cpu_req_valid_o ),
  .cpu_req_ready_i ( cpu_req_ready_i ),
  .cpu_rsp_o       ( cpu_rsp_o       ),
  .cpu_rsp_valid_o ( cpu_rsp_valid_o ),
  .cpu_rsp_ready_i ( cpu_rsp_ready_i ),
  .mem_req_o       ( mem_req_o       ),
  .mem_req_valid_o ( mem_req_valid_o ),
  .mem_req_ready_i ( mem_req_ready_i ),
  .mem_rsp_o       ( mem_rsp_o       ),
  .mem_rsp_valid_o ( mem_rsp_valid_o ),
  .mem_rsp_ready_i ( mem_rsp_ready_i ),
  .cfg_req_valid_i ( cfg_req_valid_i ),
  .cfg_req_ready_o ( cfg_req_ready_o ),
  .cfg_rsp_valid_o ( cfg_rsp_valid_o ),
  .cpu_events_i    ( cpu_events      ),
  .mem_events_i    ( mem_events      )
);

//--- bench/host_pmu_tb.sv
`timescale 1ns/10ps
`include "hd_consts.svh"

module host_pmu_tb
  import hd_pkg::*;
;

  localparam int phase_len      = 300;
  localparam int num_phases     = 3;
  localparam int readback_cyc   = 480;
  localparam int timeout_cycles = 4 * (num_phases * phase_len + readback_cyc);
  localparam int stall_max      = 6;
  localparam int outst_max      = (1 << `HD_OUTST_W) - 1;

  logic                                 clk_i = 1'b0;
  logic                                 reset_i;
  cpu_req_t                             cpu_req_i;
  logic                                 cpu_req_valid_i;
  logic                                 cpu_req_ready_o;
  cpu_req_t                             cpu_req_o;
  logic                                 cpu_req_valid_o;
  logic                                 cpu_req_ready_i;
  link_rsp_t                            cpu_rsp_i;
  logic                                 cpu_rsp_valid_i;
  logic                                 cpu_rsp_ready_o;
  link_rsp_t                            cpu_rsp_o;
  logic                                 cpu_rsp_valid_o;
  logic                                 cpu_rsp_ready_i;
  mem_req_t                             mem_req_i;
  logic                                 mem_req_valid_i;
  logic                                 mem_req_ready_o;
  mem_req_t                             mem_req_o;
  logic                                 mem_req_valid_o;
  logic                                 mem_req_ready_i;
  link_rsp_t                            mem_rsp_i;
  logic                                 mem_rsp_valid_i;
  logic                                 mem_rsp_ready_o;
  link_rsp_t                            mem_rsp_o;
  logic                                 mem_rsp_valid_o;
  logic                                 mem_rsp_ready_i;
  cfg_req_t                             cfg_req_i;
  logic                                 cfg_req_valid_i;
  logic                                 cfg_req_ready_o;
  logic [`HD_CFG_DATA_W-1:0]            cfg_rsp_data_o;
  logic                                 cfg_rsp_valid_o;
  logic                                 cfg_rsp_ready_i;
  logic [`HD_NUM_CNT-1:0]               irq_o;

  logic [31:0] lcg_state = 32'hd3ee;
  int          cycle_cnt = 0;
  // Model state per link, index 0 is CPU and 1 is memory
  int          rd_cnt[2];
  int          wr_cnt[2];
  int          rsp_cnt[2];
  int          busy_cnt[2];
  int          outst[2];
  int          ev_code[`HD_NUM_CNT] = '{`HD_EV_RD, `HD_EV_WR, `HD_EV_RSP, `HD_EV_BUSY};

  host_pmu_top u_dut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("test failed");
      $fatal(1, "simulation timed out");
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic bit chance(input int pct);
    return ((next_rand() >> 8) % 100) < pct;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("test failed");
    $fatal(1, "check failed");
  endtask

  function automatic int model_count(input int link, input int ev);
    case (ev)
      `HD_EV_RD:  return rd_cnt[link];
      `HD_EV_WR:  return wr_cnt[link];
      `HD_EV_RSP: return rsp_cnt[link];
      default:    return busy_cnt[link];
    endcase
  endfunction

  // Counters 0 and 1 watch CPU, 2 and 3 memory, unless flipped
  function automatic int expected_count(input int idx, input bit flip);
    return model_count(int'((idx >= 2) ^ flip), ev_code[idx]);
  endfunction

  function automatic logic [31:0] sel_word(input bit en, input bit link, input int ev);
    return {28'd0, en, link, ev[1:0]};
  endfunction

  task automatic clear_model();
    for (int l = 0; l < 2; l++) begin
      rd_cnt[l]   = 0;
      wr_cnt[l]   = 0;
      rsp_cnt[l]  = 0;
      busy_cnt[l] = 0;
      outst[l]    = 0;
    end
  endtask

  // One clock edge worth of handshakes on one link
  task automatic update_model(input int link, input bit req_fire, input bit wr,
                              input bit rsp_fire);
    if (outst[link] != 0) begin
      busy_cnt[link]++;
    end
    if (req_fire && wr) begin
      wr_cnt[link]++;
    end else if (req_fire) begin
      rd_cnt[link]++;
    end
    if (rsp_fire) begin
      rsp_cnt[link]++;
    end
    if (req_fire && !rsp_fire && outst[link] < outst_max) begin
      outst[link]++;
    end else if (rsp_fire && !req_fire && outst[link] > 0) begin
      outst[link]--;
    end
  endtask

  task automatic check_pass_through();
    assert (cpu_req_o == cpu_req_i && cpu_req_valid_o == cpu_req_valid_i &&
            cpu_req_ready_o == cpu_req_ready_i && cpu_rsp_o == cpu_rsp_i &&
            cpu_rsp_valid_o == cpu_rsp_valid_i && cpu_rsp_ready_o == cpu_rsp_ready_i)
      else report_error("CPU link output differs from its input");
    assert (mem_req_o == mem_req_i && mem_req_valid_o == mem_req_valid_i &&
            mem_req_ready_o == mem_req_ready_i && mem_rsp_o == mem_rsp_i &&
            mem_rsp_valid_o == mem_rsp_valid_i && mem_rsp_ready_o == mem_rsp_ready_i)
      else report_error("memory link output differs from its input");
  endtask

  // Model the last edge, then drive the next cycle; stalled streams hold
  task automatic step_links(input bit allow_req);
    logic [127:0] r;
    @(posedge clk_i);
    #1;
    update_model(0, cpu_req_valid_i && cpu_req_ready_i, cpu_req_i.write_en,
                 cpu_rsp_valid_i && cpu_rsp_ready_i);
    update_model(1, mem_req_valid_i && mem_req_ready_i, mem_req_i.write_en,
                 mem_rsp_valid_i && mem_rsp_ready_i);
    if (!cpu_req_valid_i || cpu_req_ready_i) begin
      r = {next_rand(), next_rand(), next_rand(), next_rand()};
      cpu_req_i       = r[$bits(cpu_req_t)-1:0];
      cpu_req_valid_i = allow_req && chance(50);
    end
    if (!cpu_rsp_valid_i || cpu_rsp_ready_i) begin
      r = {next_rand(), next_rand(), next_rand(), next_rand()};
      cpu_rsp_i       = r[$bits(link_rsp_t)-1:0];
      cpu_rsp_valid_i = (outst[0] != 0) && chance(50);
    end
    if (!mem_req_valid_i || mem_req_ready_i) begin
      r = {next_rand(), next_rand(), next_rand(), next_rand()};
      mem_req_i       = r[$bits(mem_req_t)-1:0];
      mem_req_valid_i = allow_req && chance(50);
    end
    if (!mem_rsp_valid_i || mem_rsp_ready_i) begin
      r = {next_rand(), next_rand(), next_rand(), next_rand()};
      mem_rsp_i       = r[$bits(link_rsp_t)-1:0];
      mem_rsp_valid_i = (outst[1] != 0) && chance(50);
    end
    cpu_req_ready_i = chance(75);
    cpu_rsp_ready_i = chance(70);
    mem_req_ready_i = chance(75);
    mem_rsp_ready_i = chance(70);
    @(negedge clk_i);
    check_pass_through();
  endtask

  // Random traffic, then drain and let the strobes settle
  task automatic run_phase(input int len);
    clear_model();
    repeat (len) step_links(1'b1);
    while (outst[0] != 0 || outst[1] != 0 || cpu_req_valid_i || mem_req_valid_i) begin
      step_links(1'b0);
    end
    repeat (4) step_links(1'b0);
  endtask

  task automatic cfg_access(input bit wr, input int addr, input logic [31:0] wdata,
                            input int max_stall, output logic [31:0] rdata);
    int stall;
    stall = (max_stall > 0) ? int'(next_rand() % 32'(max_stall + 1)) : 0;
    @(posedge clk_i);
    #1;
    cfg_req_i.write_en = wr;
    cfg_req_i.addr     = addr[`HD_CFG_ADDR_W-1:0];
    cfg_req_i.wdata    = wdata;
    cfg_req_valid_i    = 1'b1;
    cfg_rsp_ready_i    = 1'b0;
    @(negedge clk_i);
    assert (cfg_req_ready_o) else report_error("config port not ready while idle");
    @(posedge clk_i);
    #1;
    cfg_req_valid_i = 1'b0;
    @(negedge clk_i);
    assert (cfg_rsp_valid_o) else report_error("config response late after accept");
    rdata = cfg_rsp_data_o;
    // Response must hold while stalled and block new requests
    for (int s = 0; s < stall; s++) begin
      @(posedge clk_i);
      #1;
      @(negedge clk_i);
      assert (cfg_rsp_valid_o && cfg_rsp_data_o == rdata && !cfg_req_ready_o)
        else report_error("config response changed or port accepted during stall");
    end
    @(posedge clk_i);
    #1;
    cfg_rsp_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    cfg_rsp_ready_i = 1'b0;
    assert (!cfg_rsp_valid_o) else report_error("config response stayed after it was taken");
  endtask

  task automatic write_reg(input int addr, input logic [31:0] data);
    logic [31:0] rdata;
    cfg_access(1'b1, addr, data, 0, rdata);
    assert (rdata == '0)
      else report_error($sformatf("write to reg %0d answered 0x%0h", addr, rdata));
  endtask

  task automatic read_expect(input int addr, input int exp, input string what);
    logic [31:0] rdata;
    cfg_access(1'b0, addr, '0, stall_max, rdata);
    assert (rdata == 32'(exp))
      else report_error($sformatf("%s read 0x%0h, expected 0x%0h", what, rdata, exp));
  endtask

  task automatic program_sel(input bit flip, input int off_idx);
    for (int i = 0; i < `HD_NUM_CNT; i++) begin
      write_reg(`HD_REG_SEL + i, sel_word(i != off_idx, (i >= 2) ^ flip, ev_code[i]));
    end
  endtask

  initial begin
    int                     start_val[`HD_NUM_CNT];
    int                     thr[`HD_NUM_CNT];
    logic [`HD_NUM_CNT-1:0] exp_irq;
    reset_i         = 1'b1;
    cpu_req_i       = '0;
    cpu_req_valid_i = 1'b0;
    cpu_req_ready_i = 1'b0;
    cpu_rsp_i       = '0;
    cpu_rsp_valid_i = 1'b0;
    cpu_rsp_ready_i = 1'b0;
    mem_req_i       = '0;
    mem_req_valid_i = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_rsp_i       = '0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_ready_i = 1'b0;
    cfg_req_i       = '0;
    cfg_req_valid_i = 1'b0;
    cfg_rsp_ready_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    assert (irq_o == '0 && !cfg_rsp_valid_o) else report_error("outputs high after reset");

    // Direct mapping of all four counters
    program_sel(1'b0, -1);
    run_phase(phase_len);
    for (int i = 0; i < `HD_NUM_CNT; i++) begin
      read_expect(`HD_REG_CNT + i, expected_count(i, 1'b0), $sformatf("counter %0d", i));
    end

    // Other link's events, counter 3 disabled, preloaded starts
    program_sel(1'b1, 3);
    for (int i = 0; i < `HD_NUM_CNT; i++) begin
      start_val[i] = int'(next_rand() & 32'hffff);
      write_reg(`HD_REG_CNT + i, 32'(start_val[i]));
    end
    run_phase(phase_len);
    for (int i = 0; i < `HD_NUM_CNT; i++) begin
      read_expect(`HD_REG_CNT + i, (i == 3) ? start_val[i] :
                  start_val[i] + expected_count(i, 1'b1), $sformatf("counter %0d", i));
    end

    // Even counters get low thresholds, odd ones unreachable
    program_sel(1'b0, -1);
    for (int i = 0; i < `HD_NUM_CNT; i++) begin
      thr[i] = (i % 2 == 0) ? 1 + int'(next_rand() % 40) : 2000 + int'(next_rand() % 1000);
      write_reg(`HD_REG_CNT + i, '0);
      write_reg(`HD_REG_THR + i, 32'(thr[i]));
    end
    run_phase(phase_len);
    for (int i = 0; i < `HD_NUM_CNT; i++) begin
      exp_irq[i] = expected_count(i, 1'b0) >= thr[i];
      read_expect(`HD_REG_CNT + i, expected_count(i, 1'b0), $sformatf("counter %0d", i));
    end
    assert (irq_o == exp_irq)
      else report_error($sformatf("irq_o 0x%0h, expected 0x%0h", irq_o, exp_irq));
    read_expect(`HD_REG_IRQ, int'(exp_irq), "interrupt status");

    // Clear every interrupt bit
    write_reg(`HD_REG_IRQ, 32'hf);
    assert (irq_o == '0) else report_error($sformatf("irq_o 0x%0h after clear", irq_o));
    read_expect(`HD_REG_IRQ, 0, "interrupt status after clear");

    $display("test passed");
    $finish;
  end

endmodule

//--- host_pmu.f
+incdir+verilog
verilog/hd_pkg.sv
verilog/bus_event_probe.sv
verilog/pmu_counters.sv
verilog/pmu_cfg_regs.sv
verilog/host_pmu_top.sv
bench/host_pmu_asserts.sv
bench/host_pmu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := host_pmu_tb
FILELIST  := host_pmu.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
